/* Makefile */
# Verilator build and run for the global buffer config front end

VERILATOR ?= verilator
TOP       ?= glb_cfg_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

FAIL_MSG  := Simulation finished: FAIL
PASS_MSG  := Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* flist.f */
+incdir+hw
hw/glb_cfg_pkg.sv
hw/glb_axil_s_ctrl.sv
hw/glb_interrupt_regs.sv
hw/glb_tile_cfg_pipe.sv
hw/glb_cfg_top.sv
sim/glb_cfg_tb.sv

/* hw/glb_axil_s_ctrl.sv */
`include "glb_cfg.svh"

module glb_axil_s_ctrl (
    input  logic                   clk,
    input  logic                   reset,

    // AXI-Lite slave
    input  logic                   awvalid,
    output logic                   awready,
    input  glb_cfg_pkg::cfg_addr_t awaddr,
    input  logic                   wvalid,
    output logic                   wready,
    input  glb_cfg_pkg::cfg_data_t wdata,
    output logic                   bvalid,
    input  logic                   bready,
    output glb_cfg_pkg::axil_resp_t bresp,
    input  logic                   arvalid,
    output logic                   arready,
    input  glb_cfg_pkg::cfg_addr_t araddr,
    output logic                   rvalid,
    input  logic                   rready,
    output glb_cfg_pkg::cfg_data_t rdata,
    output glb_cfg_pkg::axil_resp_t rresp,

    // interrupt register block
    output logic                   intr_wr_en,
    output glb_cfg_pkg::cfg_addr_t intr_wr_addr,
    output glb_cfg_pkg::cfg_data_t intr_wr_data,
    output logic                   intr_rd_en,
    output glb_cfg_pkg::cfg_addr_t intr_rd_addr,
    input  glb_cfg_pkg::cfg_data_t intr_rd_data,
    input  logic                   intr_rd_data_valid,

    // tile configuration pipeline
    output logic                   tile_wr_en,
    output glb_cfg_pkg::cfg_addr_t tile_wr_addr,
    output glb_cfg_pkg::cfg_data_t tile_wr_data,
    output logic                   tile_rd_en,
    output glb_cfg_pkg::cfg_addr_t tile_rd_addr,
    input  glb_cfg_pkg::cfg_data_t tile_rd_data,
    input  logic                   tile_rd_data_valid,

    output logic                   cfg_wr_tile_clk_en,
    output logic                   cfg_wr_intr_clk_en,
    output logic                   cfg_rd_tile_clk_en,
    output logic                   cfg_rd_intr_clk_en
);

    localparam int WAIT_W = $clog2(`GLB_NUM_TILES) + 1;

    typedef enum logic [2:0] {
        WR_IDLE,
        WR_REQ_INTERRUPT,
        WR_REQ_TILE,
        WR_WAIT,
        WR_RESP
    } wr_state_t;

    typedef enum logic [2:0] {
        RD_IDLE,
        RD_REQ_INTERRUPT,
        RD_REQ_TILE,
        RD_WAIT,
        RD_RESP
    } rd_state_t;

    wr_state_t         wr_state;
    rd_state_t         rd_state;
    logic [WAIT_W-1:0] wr_wait_cnt;
    logic              rd_is_tile;
    logic              tile_wr_issue;

    // enables before the half-cycle shift
    logic              wr_tile_clk_en_p;
    logic              wr_intr_clk_en_p;
    logic              rd_tile_clk_en_p;
    logic              rd_intr_clk_en_p;

    // no error responses
    assign bresp = glb_cfg_pkg::OKAY;
    assign rresp = glb_cfg_pkg::OKAY;

    // tile write pulse goes out next cycle, the pipeline takes one request per cycle
    assign tile_wr_issue = (wr_state == WR_REQ_TILE) && wvalid && wready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_state <= WR_IDLE;
            wr_wait_cnt <= '0;
            wr_tile_clk_en_p <= 1'b0;
            wr_intr_clk_en_p <= 1'b0;
            awready <= 1'b1;
            wready <= 1'b1;
            bvalid <= 1'b0;
            intr_wr_en <= 1'b0;
            intr_wr_addr <= '0;
            intr_wr_data <= '0;
            tile_wr_en <= 1'b0;
            tile_wr_addr <= '0;
            tile_wr_data <= '0;
        end else begin
            case (wr_state)
                WR_IDLE: begin
                    if (awvalid && awready) begin
                        awready <= 1'b0;
                        // addr[11] picks the target
                        if (awaddr[`GLB_AXI_ADDR_WIDTH-1]) begin
                            wr_state <= WR_REQ_TILE;
                            wr_tile_clk_en_p <= 1'b1;
                            tile_wr_addr <= awaddr;
                        end else begin
                            wr_state <= WR_REQ_INTERRUPT;
                            wr_intr_clk_en_p <= 1'b1;
                            intr_wr_addr <= awaddr;
                        end
                    end
                end
                WR_REQ_INTERRUPT: begin
                    if (wvalid && wready) begin
                        wready <= 1'b0;
                        intr_wr_en <= 1'b1;
                        intr_wr_data <= wdata;
                        wr_wait_cnt <= '0;
                        wr_state <= WR_WAIT;
                    end
                end
                WR_REQ_TILE: begin
                    if (tile_wr_issue) begin
                        wready <= 1'b0;
                        tile_wr_en <= 1'b1;
                        tile_wr_data <= wdata;
                        // let the request reach the last tile
                        wr_wait_cnt <= WAIT_W'(`GLB_NUM_TILES);
                        wr_state <= WR_WAIT;
                    end
                end
                WR_WAIT: begin
                    intr_wr_en <= 1'b0;
                    tile_wr_en <= 1'b0;
                    if (wr_wait_cnt == '0) begin
                        bvalid <= 1'b1;
                        wr_state <= WR_RESP;
                    end else begin
                        wr_wait_cnt <= wr_wait_cnt - 1'b1;
                    end
                end
                WR_RESP: begin
                    if (bvalid && bready) begin
                        bvalid <= 1'b0;
                        awready <= 1'b1;
                        wready <= 1'b1;
                        wr_tile_clk_en_p <= 1'b0;
                        wr_intr_clk_en_p <= 1'b0;
                        wr_state <= WR_IDLE;
                    end
                end
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_state <= RD_IDLE;
            rd_is_tile <= 1'b0;
            rd_tile_clk_en_p <= 1'b0;
            rd_intr_clk_en_p <= 1'b0;
            arready <= 1'b1;
            rvalid <= 1'b0;
            rdata <= '0;
            intr_rd_en <= 1'b0;
            intr_rd_addr <= '0;
            tile_rd_en <= 1'b0;
            tile_rd_addr <= '0;
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    if (arvalid && arready) begin
                        arready <= 1'b0;
                        rd_is_tile <= araddr[`GLB_AXI_ADDR_WIDTH-1];
                        if (araddr[`GLB_AXI_ADDR_WIDTH-1]) begin
                            rd_state <= RD_REQ_TILE;
                            rd_tile_clk_en_p <= 1'b1;
                            tile_rd_addr <= araddr;
                        end else begin
                            rd_state <= RD_REQ_INTERRUPT;
                            rd_intr_clk_en_p <= 1'b1;
                            intr_rd_addr <= araddr;
                        end
                    end
                end
                RD_REQ_INTERRUPT: begin
                    intr_rd_en <= 1'b1;
                    rd_state <= RD_WAIT;
                end
                RD_REQ_TILE: begin
                    // hold off one cycle if a tile write enters stage 0
                    if (!tile_wr_issue) begin
                        tile_rd_en <= 1'b1;
                        rd_state <= RD_WAIT;
                    end
                end
                RD_WAIT: begin
                    intr_rd_en <= 1'b0;
                    tile_rd_en <= 1'b0;
                    if (rd_is_tile && tile_rd_data_valid) begin
                        rdata <= tile_rd_data;
                        rvalid <= 1'b1;
                        rd_state <= RD_RESP;
                    end else if (!rd_is_tile && intr_rd_data_valid) begin
                        rdata <= intr_rd_data;
                        rvalid <= 1'b1;
                        rd_state <= RD_RESP;
                    end
                end
                RD_RESP: begin
                    if (rvalid && rready) begin
                        rvalid <= 1'b0;
                        arready <= 1'b1;
                        rd_tile_clk_en_p <= 1'b0;
                        rd_intr_clk_en_p <= 1'b0;
                        rd_state <= RD_IDLE;
                    end
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    // half-cycle shift onto the falling edge
    always_ff @(negedge clk or posedge reset) begin
        if (reset) begin
            cfg_wr_tile_clk_en <= 1'b0;
            cfg_wr_intr_clk_en <= 1'b0;
            cfg_rd_tile_clk_en <= 1'b0;
            cfg_rd_intr_clk_en <= 1'b0;
        end else begin
            cfg_wr_tile_clk_en <= wr_tile_clk_en_p;
            cfg_wr_intr_clk_en <= wr_intr_clk_en_p;
            cfg_rd_tile_clk_en <= rd_tile_clk_en_p;
            cfg_rd_intr_clk_en <= rd_intr_clk_en_p;
        end
    end

    // response held under back-pressure
    assert property (@(posedge clk) disable iff (reset) bvalid && !bready |=> bvalid);
    assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata));

    // one write target at a time
    assert property (@(posedge clk) disable iff (reset) !(intr_wr_en && tile_wr_en));

endmodule

/* hw/glb_cfg.svh */
`ifndef GLB_CFG_SVH
`define GLB_CFG_SVH

// AXI-Lite and configuration bus widths
`define GLB_AXI_ADDR_WIDTH 12
`define GLB_DATA_WIDTH 32

// tile group size, also the controller's write wait on the tile path
`define GLB_NUM_TILES 4
`define GLB_REGS_PER_TILE 8

// address map for the tile side, addr[11] set
`define GLB_TILE_ID_LSB 8
`define GLB_REG_IDX_LSB 2

// interrupt register indices at addr[3:2]
`define GLB_INTR_ENABLE_IDX 0
`define GLB_INTR_STATUS_IDX 1

`endif

/* hw/glb_cfg_pkg.sv */
`include "glb_cfg.svh"

package glb_cfg_pkg;

    // address shared by the AXI-Lite port and both config targets
    typedef logic [`GLB_AXI_ADDR_WIDTH-1:0] cfg_addr_t;

    typedef logic [`GLB_DATA_WIDTH-1:0] cfg_data_t;

    // index of one tile in the group
    typedef logic [$clog2(`GLB_NUM_TILES)-1:0] tile_id_t;

    // standard AXI response encoding
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axil_resp_t;

endpackage

/* hw/glb_cfg_top.sv */
`include "glb_cfg.svh"

module glb_cfg_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      awvalid,
    output logic                      awready,
    input  glb_cfg_pkg::cfg_addr_t    awaddr,
    input  logic                      wvalid,
    output logic                      wready,
    input  glb_cfg_pkg::cfg_data_t    wdata,
    output logic                      bvalid,
    input  logic                      bready,
    output glb_cfg_pkg::axil_resp_t   bresp,
    input  logic                      arvalid,
    output logic                      arready,
    input  glb_cfg_pkg::cfg_addr_t    araddr,
    output logic                      rvalid,
    input  logic                      rready,
    output glb_cfg_pkg::cfg_data_t    rdata,
    output glb_cfg_pkg::axil_resp_t   rresp,
    input  logic [`GLB_NUM_TILES-1:0] tile_done,
    output logic                      irq,
    output logic                      cfg_wr_tile_clk_en,
    output logic                      cfg_wr_intr_clk_en,
    output logic                      cfg_rd_tile_clk_en,
    output logic                      cfg_rd_intr_clk_en
);

    logic                   intr_wr_en;
    glb_cfg_pkg::cfg_addr_t intr_wr_addr;
    glb_cfg_pkg::cfg_data_t intr_wr_data;
    logic                   intr_rd_en;
    glb_cfg_pkg::cfg_addr_t intr_rd_addr;
    glb_cfg_pkg::cfg_data_t intr_rd_data;
    logic                   intr_rd_data_valid;

    logic                   tile_wr_en;
    glb_cfg_pkg::cfg_addr_t tile_wr_addr;
    glb_cfg_pkg::cfg_data_t tile_wr_data;
    logic                   tile_rd_en;
    glb_cfg_pkg::cfg_addr_t tile_rd_addr;
    glb_cfg_pkg::cfg_data_t tile_rd_data;
    logic                   tile_rd_data_valid;

    glb_axil_s_ctrl u_ctrl (
        .clk                (clk),
        .reset              (reset),
        .awvalid            (awvalid),
        .awready            (awready),
        .awaddr             (awaddr),
        .wvalid             (wvalid),
        .wready             (wready),
        .wdata              (wdata),
        .bvalid             (bvalid),
        .bready             (bready),
        .bresp              (bresp),
        .arvalid            (arvalid),
        .arready            (arready),
        .araddr             (araddr),
        .rvalid             (rvalid),
        .rready             (rready),
        .rdata              (rdata),
        .rresp              (rresp),
        .intr_wr_en         (intr_wr_en),
        .intr_wr_addr       (intr_wr_addr),
        .intr_wr_data       (intr_wr_data),
        .intr_rd_en         (intr_rd_en),
        .intr_rd_addr       (intr_rd_addr),
        .intr_rd_data       (intr_rd_data),
        .intr_rd_data_valid (intr_rd_data_valid),
        .tile_wr_en         (tile_wr_en),
        .tile_wr_addr       (tile_wr_addr),
        .tile_wr_data       (tile_wr_data),
        .tile_rd_en         (tile_rd_en),
        .tile_rd_addr       (tile_rd_addr),
        .tile_rd_data       (tile_rd_data),
        .tile_rd_data_valid (tile_rd_data_valid),
        .cfg_wr_tile_clk_en (cfg_wr_tile_clk_en),
        .cfg_wr_intr_clk_en (cfg_wr_intr_clk_en),
        .cfg_rd_tile_clk_en (cfg_rd_tile_clk_en),
        .cfg_rd_intr_clk_en (cfg_rd_intr_clk_en)
    );

    glb_interrupt_regs u_intr (
        .clk           (clk),
        .reset         (reset),
        .wr_en         (intr_wr_en),
        .wr_addr       (intr_wr_addr),
        .wr_data       (intr_wr_data),
        .rd_en         (intr_rd_en),
        .rd_addr       (intr_rd_addr),
        .tile_done     (tile_done),
        .rd_data       (intr_rd_data),
        .rd_data_valid (intr_rd_data_valid),
        .irq           (irq)
    );

    glb_tile_cfg_pipe u_tile (
        .clk           (clk),
        .reset         (reset),
        .wr_en         (tile_wr_en),
        .wr_addr       (tile_wr_addr),
        .wr_data       (tile_wr_data),
        .rd_en         (tile_rd_en),
        .rd_addr       (tile_rd_addr),
        .rd_data       (tile_rd_data),
        .rd_data_valid (tile_rd_data_valid)
    );

endmodule

/* hw/glb_interrupt_regs.sv */
`include "glb_cfg.svh"

module glb_interrupt_regs (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       wr_en,
    input  glb_cfg_pkg::cfg_addr_t     wr_addr,
    input  glb_cfg_pkg::cfg_data_t     wr_data,
    input  logic                       rd_en,
    input  glb_cfg_pkg::cfg_addr_t     rd_addr,
    input  logic [`GLB_NUM_TILES-1:0]  tile_done,
    output glb_cfg_pkg::cfg_data_t     rd_data,
    output logic                       rd_data_valid,
    output logic                       irq
);

    localparam int NUM_TILES = `GLB_NUM_TILES;

    logic [NUM_TILES-1:0] intr_enable;
    logic [NUM_TILES-1:0] intr_status;
    logic [NUM_TILES-1:0] status_clr;
    logic [1:0]           wr_idx;
    logic [1:0]           rd_idx;

    assign wr_idx = wr_addr[`GLB_REG_IDX_LSB +: 2];
    assign rd_idx = rd_addr[`GLB_REG_IDX_LSB +: 2];

    // write 1 to clear
    assign status_clr = (wr_en && wr_idx == 2'(`GLB_INTR_STATUS_IDX)) ?
                        wr_data[NUM_TILES-1:0] : '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            intr_enable <= '0;
            intr_status <= '0;
            irq <= 1'b0;
            rd_data <= '0;
            rd_data_valid <= 1'b0;
        end else begin
            if (wr_en && wr_idx == 2'(`GLB_INTR_ENABLE_IDX)) begin
                intr_enable <= wr_data[NUM_TILES-1:0];
            end
            // a done pulse wins over a clear in the same cycle
            intr_status <= (intr_status & ~status_clr) | tile_done;
            irq <= |(intr_status & intr_enable);

            rd_data_valid <= rd_en;
            if (rd_en) begin
                case (rd_idx)
                    2'(`GLB_INTR_ENABLE_IDX): rd_data <= glb_cfg_pkg::cfg_data_t'(intr_enable);
                    2'(`GLB_INTR_STATUS_IDX): rd_data <= glb_cfg_pkg::cfg_data_t'(intr_status);
                    default:                  rd_data <= '0;
                endcase
            end
        end
    end

    // one single-cycle read request at a time from the controller
    assert property (@(posedge clk) disable iff (reset) rd_en |=> !rd_en);

endmodule

/* hw/glb_tile_cfg_pipe.sv */
`include "glb_cfg.svh"

module glb_tile_cfg_pipe (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   wr_en,
    input  glb_cfg_pkg::cfg_addr_t wr_addr,
    input  glb_cfg_pkg::cfg_data_t wr_data,
    input  logic                   rd_en,
    input  glb_cfg_pkg::cfg_addr_t rd_addr,
    output glb_cfg_pkg::cfg_data_t rd_data,
    output logic                   rd_data_valid
);

    localparam int NUM_TILES = `GLB_NUM_TILES;
    localparam int TILE_W = $clog2(`GLB_NUM_TILES);
    localparam int IDX_W = $clog2(`GLB_REGS_PER_TILE);

    glb_cfg_pkg::cfg_addr_t req_addr;
    logic                   req_hit;

    // request stages, stage k sits at tile k
    logic [NUM_TILES-1:0]   s_valid;
    logic [NUM_TILES-1:0]   s_write;
    logic [NUM_TILES-1:0]   s_hit;
    logic [NUM_TILES-1:0]   s_match;
    glb_cfg_pkg::tile_id_t  s_tile [NUM_TILES];
    logic [IDX_W-1:0]       s_idx [NUM_TILES];
    glb_cfg_pkg::cfg_data_t s_data [NUM_TILES];

    // read return, one stage behind the request
    logic [NUM_TILES-1:0]   ret_valid;
    glb_cfg_pkg::cfg_data_t ret_data [NUM_TILES];

    glb_cfg_pkg::cfg_data_t regs [NUM_TILES][`GLB_REGS_PER_TILE];

    assign req_addr = wr_en ? wr_addr : rd_addr;
    // tile ids past the group are unmapped
    assign req_hit = req_addr[`GLB_AXI_ADDR_WIDTH-2:`GLB_TILE_ID_LSB] < NUM_TILES;

    always_comb begin
        for (int k = 0; k < NUM_TILES; k++) begin
            s_match[k] = s_hit[k] && (s_tile[k] == glb_cfg_pkg::tile_id_t'(k));
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s_valid <= '0;
            s_write <= '0;
            ret_valid <= '0;
        end else begin
            s_valid[0] <= wr_en | rd_en;
            s_write[0] <= wr_en;
            ret_valid[0] <= s_valid[0] & ~s_write[0];
            for (int k = 1; k < NUM_TILES; k++) begin
                s_valid[k] <= s_valid[k-1];
                s_write[k] <= s_write[k-1];
                ret_valid[k] <= s_valid[k] & ~s_write[k];
            end
        end
    end

    always_ff @(posedge clk) begin
        s_hit[0] <= req_hit;
        s_tile[0] <= req_addr[`GLB_TILE_ID_LSB +: TILE_W];
        s_idx[0] <= req_addr[`GLB_REG_IDX_LSB +: IDX_W];
        s_data[0] <= wr_data;
        for (int k = 1; k < NUM_TILES; k++) begin
            s_hit[k] <= s_hit[k-1];
            s_tile[k] <= s_tile[k-1];
            s_idx[k] <= s_idx[k-1];
            s_data[k] <= s_data[k-1];
        end

        for (int k = 0; k < NUM_TILES; k++) begin
            if (s_valid[k] && s_write[k] && s_match[k]) begin
                regs[k][s_idx[k]] <= s_data[k];
            end
        end

        // owning tile drops its word in, everyone else passes it on
        ret_data[0] <= s_match[0] ? regs[0][s_idx[0]] : '0;
        for (int k = 1; k < NUM_TILES; k++) begin
            ret_data[k] <= s_match[k] ? regs[k][s_idx[k]] : ret_data[k-1];
        end
    end

    assign rd_data = ret_data[NUM_TILES-1];
    assign rd_data_valid = ret_valid[NUM_TILES-1];

    // stage 0 takes a single request, the controller keeps reads and writes apart
    assert property (@(posedge clk) disable iff (reset) !(wr_en && rd_en));

endmodule

/* sim/glb_cfg_tb.sv */
`include "glb_cfg.svh"

module glb_cfg_tb;

    localparam int NUM_TILES = `GLB_NUM_TILES;
    localparam int NUM_REGS = `GLB_REGS_PER_TILE;
    localparam int BP_MAX = 4;

    typedef enum logic [1:0] {
        OP_WRITE,
        OP_READ,
        OP_DONE
    } op_t;

    typedef struct packed {
        op_t                    op;
        glb_cfg_pkg::cfg_addr_t addr;
        glb_cfg_pkg::cfg_data_t data;
        glb_cfg_pkg::cfg_data_t exp;
        logic                   exp_irq;
        int                     bp;
    } entry_t;

    logic                    clk;
    logic                    reset;
    logic                    awvalid;
    logic                    awready;
    glb_cfg_pkg::cfg_addr_t  awaddr;
    logic                    wvalid;
    logic                    wready;
    glb_cfg_pkg::cfg_data_t  wdata;
    logic                    bvalid;
    logic                    bready;
    glb_cfg_pkg::axil_resp_t bresp;
    logic                    arvalid;
    logic                    arready;
    glb_cfg_pkg::cfg_addr_t  araddr;
    logic                    rvalid;
    logic                    rready;
    glb_cfg_pkg::cfg_data_t  rdata;
    glb_cfg_pkg::axil_resp_t rresp;
    logic [NUM_TILES-1:0]    tile_done;
    logic                    irq;
    logic                    cfg_wr_tile_clk_en;
    logic                    cfg_wr_intr_clk_en;
    logic                    cfg_rd_tile_clk_en;
    logic                    cfg_rd_intr_clk_en;

    // stimulus table and the shadow model used while building it
    entry_t                  table_q[$];
    glb_cfg_pkg::cfg_data_t  tile_shadow [NUM_TILES][NUM_REGS];
    logic [NUM_TILES-1:0]    sh_enable;
    logic [NUM_TILES-1:0]    sh_status;
    logic [31:0]             lcg_state;
    int                      cycle_count = 0;
    int                      cycle_limit = 0;

    glb_cfg_top u_dut (
        .clk                (clk),
        .reset              (reset),
        .awvalid            (awvalid),
        .awready            (awready),
        .awaddr             (awaddr),
        .wvalid             (wvalid),
        .wready             (wready),
        .wdata              (wdata),
        .bvalid             (bvalid),
        .bready             (bready),
        .bresp              (bresp),
        .arvalid            (arvalid),
        .arready            (arready),
        .araddr             (araddr),
        .rvalid             (rvalid),
        .rready             (rready),
        .rdata              (rdata),
        .rresp              (rresp),
        .tile_done          (tile_done),
        .irq                (irq),
        .cfg_wr_tile_clk_en (cfg_wr_tile_clk_en),
        .cfg_wr_intr_clk_en (cfg_wr_intr_clk_en),
        .cfg_rd_tile_clk_en (cfg_rd_tile_clk_en),
        .cfg_rd_intr_clk_en (cfg_rd_intr_clk_en)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            abort_run($sformatf("simulation timed out after %0d cycles", cycle_count));
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input glb_cfg_pkg::cfg_data_t got,
                              input glb_cfg_pkg::cfg_data_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_resp(input string name, input glb_cfg_pkg::axil_resp_t got,
                              input glb_cfg_pkg::axil_resp_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_enables(input logic wr_tile, input logic wr_intr,
                                 input logic rd_tile, input logic rd_intr);
        check_bit("cfg_wr_tile_clk_en", cfg_wr_tile_clk_en, wr_tile);
        check_bit("cfg_wr_intr_clk_en", cfg_wr_intr_clk_en, wr_intr);
        check_bit("cfg_rd_tile_clk_en", cfg_rd_tile_clk_en, rd_tile);
        check_bit("cfg_rd_intr_clk_en", cfg_rd_intr_clk_en, rd_intr);
    endtask

    function automatic glb_cfg_pkg::cfg_data_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic glb_cfg_pkg::cfg_addr_t tile_addr(input int tile, input int idx);
        return glb_cfg_pkg::cfg_addr_t'(12'h800 | (tile << `GLB_TILE_ID_LSB) |
                                        (idx << `GLB_REG_IDX_LSB));
    endfunction

    function automatic glb_cfg_pkg::cfg_addr_t intr_addr(input int idx);
        return glb_cfg_pkg::cfg_addr_t'(idx << `GLB_REG_IDX_LSB);
    endfunction

    function automatic void push_entry(input op_t op, input glb_cfg_pkg::cfg_addr_t addr,
                                       input glb_cfg_pkg::cfg_data_t data,
                                       input glb_cfg_pkg::cfg_data_t exp, input int bp);
        entry_t e;
        e.op = op;
        e.addr = addr;
        e.data = data;
        e.exp = exp;
        e.exp_irq = |(sh_status & sh_enable);
        e.bp = bp;
        table_q.push_back(e);
    endfunction

    function automatic void add_write(input glb_cfg_pkg::cfg_addr_t addr,
                                      input glb_cfg_pkg::cfg_data_t data, input int bp);
        int tile;
        int idx;
        tile = int'(addr[10:`GLB_TILE_ID_LSB]);
        if (addr[11]) begin
            idx = int'(addr[`GLB_REG_IDX_LSB +: 3]);
            if (tile < NUM_TILES) begin
                tile_shadow[tile][idx] = data;
            end
        end else begin
            idx = int'(addr[`GLB_REG_IDX_LSB +: 2]);
            if (idx == `GLB_INTR_ENABLE_IDX) begin
                sh_enable = data[NUM_TILES-1:0];
            end else if (idx == `GLB_INTR_STATUS_IDX) begin
                // write 1 to clear
                sh_status = sh_status & ~data[NUM_TILES-1:0];
            end
        end
        push_entry(OP_WRITE, addr, data, '0, bp);
    endfunction

    function automatic void add_read(input glb_cfg_pkg::cfg_addr_t addr, input int bp);
        glb_cfg_pkg::cfg_data_t exp;
        int tile;
        int idx;
        exp = '0;
        tile = int'(addr[10:`GLB_TILE_ID_LSB]);
        if (addr[11]) begin
            idx = int'(addr[`GLB_REG_IDX_LSB +: 3]);
            // unmapped tile ids read as zero
            if (tile < NUM_TILES) begin
                exp = tile_shadow[tile][idx];
            end
        end else begin
            idx = int'(addr[`GLB_REG_IDX_LSB +: 2]);
            if (idx == `GLB_INTR_ENABLE_IDX) begin
                exp = glb_cfg_pkg::cfg_data_t'(sh_enable);
            end else if (idx == `GLB_INTR_STATUS_IDX) begin
                exp = glb_cfg_pkg::cfg_data_t'(sh_status);
            end
        end
        push_entry(OP_READ, addr, '0, exp, bp);
    endfunction

    function automatic void add_done(input logic [NUM_TILES-1:0] mask);
        sh_status = sh_status | mask;
        push_entry(OP_DONE, '0, glb_cfg_pkg::cfg_data_t'(mask), '0, 0);
    endfunction

    task automatic build_table();
        int perm;
        sh_enable = '0;
        sh_status = '0;
        // interrupt status, enable and irq
        add_read(intr_addr(`GLB_INTR_STATUS_IDX), 0);
        add_done(4'b0101);
        add_read(intr_addr(`GLB_INTR_STATUS_IDX), 0);
        add_write(intr_addr(`GLB_INTR_ENABLE_IDX), 32'h2, 0);
        add_done(4'b0010);
        add_read(intr_addr(`GLB_INTR_ENABLE_IDX), 2);
        add_write(intr_addr(`GLB_INTR_ENABLE_IDX), 32'hc, 0);
        add_write(intr_addr(`GLB_INTR_STATUS_IDX), 32'h4, 3);
        add_read(intr_addr(`GLB_INTR_STATUS_IDX), BP_MAX);
        add_write(intr_addr(`GLB_INTR_STATUS_IDX), 32'h3, 0);
        add_read(intr_addr(`GLB_INTR_STATUS_IDX), 0);
        add_read(intr_addr(2), 0);
        // fill every tile register
        for (int t = 0; t < NUM_TILES; t++) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                add_write(tile_addr(t, r), lcg_next(), ((t + r) % 3 == 0) ? 2 : 0);
            end
        end
        // read back in scrambled order, 13 is coprime with the register count
        for (int i = 0; i < NUM_TILES * NUM_REGS; i++) begin
            perm = (i * 13 + 7) % (NUM_TILES * NUM_REGS);
            add_read(tile_addr(perm % NUM_TILES, perm / NUM_TILES), (i % 4 == 1) ? BP_MAX : 0);
        end
        add_read(tile_addr(5, 3), 0);
        add_read(tile_addr(7, 0), 1);
    endtask

    // all drivers start and end on a falling edge
    task automatic axil_write(input glb_cfg_pkg::cfg_addr_t addr,
                              input glb_cfg_pkg::cfg_data_t data, input int bp);
        logic is_tile;
        is_tile = addr[`GLB_AXI_ADDR_WIDTH-1];
        awvalid = 1'b1;
        awaddr = addr;
        bready = 1'b0;
        while (!awready) @(negedge clk);
        @(negedge clk);
        awvalid = 1'b0;
        // W is taken in the state after AW
        wvalid = 1'b1;
        wdata = data;
        while (!wready) @(negedge clk);
        @(negedge clk);
        wvalid = 1'b0;
        while (!bvalid) @(negedge clk);
        check_resp("bresp", bresp, glb_cfg_pkg::OKAY);
        check_enables(is_tile, !is_tile, 1'b0, 1'b0);
        repeat (bp) begin
            @(negedge clk);
            check_bit("bvalid", bvalid, 1'b1);
        end
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
        @(negedge clk);
        check_enables(1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic axil_read(input glb_cfg_pkg::cfg_addr_t addr, input int bp,
                             output glb_cfg_pkg::cfg_data_t data);
        logic is_tile;
        is_tile = addr[`GLB_AXI_ADDR_WIDTH-1];
        arvalid = 1'b1;
        araddr = addr;
        rready = 1'b0;
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        data = rdata;
        check_resp("rresp", rresp, glb_cfg_pkg::OKAY);
        check_enables(1'b0, 1'b0, is_tile, !is_tile);
        // response must hold still under back-pressure
        repeat (bp) begin
            @(negedge clk);
            check_bit("rvalid", rvalid, 1'b1);
            check_data("rdata", rdata, data);
        end
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
        @(negedge clk);
        check_enables(1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic pulse_done(input logic [NUM_TILES-1:0] mask);
        tile_done = mask;
        @(negedge clk);
        tile_done = '0;
        // status, then irq one cycle later
        repeat (2) @(negedge clk);
    endtask

    initial begin
        entry_t e;
        glb_cfg_pkg::cfg_data_t got;
        awvalid = 1'b0;
        awaddr = '0;
        wvalid = 1'b0;
        wdata = '0;
        bready = 1'b0;
        arvalid = 1'b0;
        araddr = '0;
        rready = 1'b0;
        tile_done = '0;
        reset = 1'b1;
        lcg_state = 32'h39ffaa28;
        build_table();
        cycle_limit = table_q.size() * (2 * NUM_TILES + 20 + BP_MAX) + 100;

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_enables(1'b0, 1'b0, 1'b0, 1'b0);
        check_bit("irq", irq, 1'b0);
        check_bit("awready", awready, 1'b1);
        check_bit("arready", arready, 1'b1);

        foreach (table_q[i]) begin
            e = table_q[i];
            case (e.op)
                OP_WRITE: axil_write(e.addr, e.data, e.bp);
                OP_READ: begin
                    axil_read(e.addr, e.bp, got);
                    check_data("rdata", got, e.exp);
                end
                default: pulse_done(e.data[NUM_TILES-1:0]);
            endcase
            check_bit("irq", irq, e.exp_irq);
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
